// File: Bender.yml
package:
  name: memory_stage

sources:
  - files:
      - common/memStagePkg.sv
      - common/memCsrPkg.sv
      - common/cacheMemIf.sv
      - common/sbCacheIf.sv
      - hw/storeBuffer.sv
      - hw/lineMemory.sv
      - hw/memCsr.sv
      - dCache/dCache.sv
      - hw/memoryStage.sv
  - target: test
    files:
      - verif/memoryStage_assert.sv
      - verif/memoryStageTb.sv

// File: common/cacheMemIf.sv
`default_nettype none

interface cacheMemIf;

   memStagePkg::lineAddress lineAddr;
   memStagePkg::cacheLine writeLine;
   memStagePkg::cacheLine readLine;
   logic read;
   logic write;
   logic ready;

   modport cache (
      output lineAddr,
      output writeLine,
      output read,
      output write,
      input  readLine,
      input  ready
   );

   modport memory (
      input  lineAddr,
      input  writeLine,
      input  read,
      input  write,
      output readLine,
      output ready
   );

endinterface

`default_nettype wire

// File: common/memCsrPkg.sv
`default_nettype none

package memCsrPkg;

   localparam int APB_ADDR_SIZE = 8;

   // Register map.
   localparam logic [APB_ADDR_SIZE-1:0] CTRL_OFFSET = 8'h00;
   localparam logic [APB_ADDR_SIZE-1:0] HITS_OFFSET = 8'h04;
   localparam logic [APB_ADDR_SIZE-1:0] MISSES_OFFSET = 8'h08;
   localparam logic [APB_ADDR_SIZE-1:0] DRAINS_OFFSET = 8'h0C;
   localparam logic [APB_ADDR_SIZE-1:0] STATUS_OFFSET = 8'h10;

   // CTRL bits.
   localparam int CTRL_BYPASS = 0;
   localparam int CTRL_CLEAR = 1;

endpackage

`default_nettype wire

// File: common/memStagePkg.sv
`default_nettype none

package memStagePkg;

   // Pipeline word sizes.
   localparam int WORD_SIZE = 32;
   localparam int REG_ADDR_SIZE = 5;

   // Cache geometry.
   localparam int LINE_WORDS = 4;
   localparam int LINE_SIZE = 128;
   localparam int CACHE_LINES = 16;
   localparam int INDEX_SIZE = 4;
   localparam int TAG_SIZE = 24;

   // Backing memory and store buffer.
   localparam int MEM_LATENCY = 5;
   localparam int MEM_LINES = 256;
   localparam int SB_DEPTH = 4;

   typedef logic [WORD_SIZE-5:0] lineAddress;
   typedef logic [LINE_SIZE-1:0] cacheLine;

   typedef struct packed {
      logic [TAG_SIZE-1:0] tag;
      logic [INDEX_SIZE-1:0] index;
      logic [1:0] wordOffset;
      logic [1:0] byteOffset;
   } addressFields;

   // Same address word, seen raw or split into its cache fields.
   typedef union packed {
      logic [WORD_SIZE-1:0] raw;
      addressFields fields;
   } byteAddress;

endpackage

`default_nettype wire

// File: common/sbCacheIf.sv
`default_nettype none

interface sbCacheIf;

   logic drainValid;
   logic drainReady;
   memStagePkg::byteAddress drainAddr;
   logic [memStagePkg::WORD_SIZE-1:0] drainData;
   logic [3:0] drainMask;

   // Head entry of the store buffer.
   modport buffer (
      output drainValid,
      output drainAddr,
      output drainData,
      output drainMask,
      input  drainReady
   );

   modport cache (
      input  drainValid,
      input  drainAddr,
      input  drainData,
      input  drainMask,
      output drainReady
   );

endinterface

`default_nettype wire

// File: dCache/dCache.sv
`default_nettype none

module dCache (
   input  logic clk,
   input  logic rst,
   input  memStagePkg::byteAddress loadAddress,
   input  logic loadRequest,
   output logic [memStagePkg::WORD_SIZE-1:0] loadData,
   output logic loadBusy,
   input  logic bypass,
   output logic hitEvent,
   output logic missEvent,
   output logic drainEvent,
   sbCacheIf.cache sb,
   cacheMemIf.cache mem
);

   typedef enum logic [1:0] {idle, fill, writeThrough} cacheState;

   cacheState state;
   logic [memStagePkg::TAG_SIZE-1:0] tags [memStagePkg::CACHE_LINES];
   logic [memStagePkg::CACHE_LINES-1:0] valid;
   memStagePkg::cacheLine lines [memStagePkg::CACHE_LINES];
   memStagePkg::byteAddress lookupAddress, fillAddress;
   memStagePkg::cacheLine baseLine, mergedLine, pendingLine, loadLine;
   logic drainLookup, lookupHit, fillForDrain, afterFill, bypassServe;

   // Loads win the lookup port over drains.
   assign drainLookup = !loadRequest && sb.drainValid;
   assign lookupAddress = loadRequest ? loadAddress : sb.drainAddr;
   assign lookupHit = !bypass && valid[lookupAddress.fields.index] &&
                      tags[lookupAddress.fields.index] == lookupAddress.fields.tag;

   // Bypassed fill hands the word straight from memory.
   assign bypassServe = state == fill && mem.ready && !fillForDrain && bypass;
   assign loadLine = bypassServe ? mem.readLine : lines[loadAddress.fields.index];
   assign loadData = loadLine[loadAddress.fields.wordOffset * memStagePkg::WORD_SIZE +:
                              memStagePkg::WORD_SIZE];

   // Drain bytes merged into the cached or freshly filled line.
   assign baseLine = (state == fill) ? mem.readLine : lines[sb.drainAddr.fields.index];

   always_comb begin
      mergedLine = baseLine;
      for (int b = 0; b < 4; b++) begin
         if (sb.drainMask[b]) begin
            mergedLine[sb.drainAddr.fields.wordOffset * memStagePkg::WORD_SIZE + b * 8 +: 8] =
               sb.drainData[b * 8 +: 8];
         end
      end
   end

   assign mem.writeLine = pendingLine;
   assign sb.drainReady = state == writeThrough && mem.ready;
   assign drainEvent = sb.drainReady;

   always_comb begin
      loadBusy = 1'b0;
      hitEvent = 1'b0;
      missEvent = 1'b0;
      mem.read = 1'b0;
      mem.write = 1'b0;
      mem.lineAddr = {fillAddress.fields.tag, fillAddress.fields.index};
      case (state)
         idle: begin
            mem.lineAddr = {lookupAddress.fields.tag, lookupAddress.fields.index};
            if (loadRequest && !afterFill) begin
               hitEvent = lookupHit;
               missEvent = !lookupHit;
               loadBusy = !lookupHit;
               mem.read = !lookupHit;
            end else if (drainLookup) begin
               hitEvent = lookupHit;
               missEvent = !lookupHit;
               mem.read = !lookupHit;
            end
         end
         fill: begin
            mem.read = 1'b1;
            loadBusy = loadRequest && !bypassServe;
         end
         default: begin
            mem.write = 1'b1;
            loadBusy = loadRequest;
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= idle;
         valid <= '0;
         fillAddress <= '0;
         fillForDrain <= 1'b0;
         afterFill <= 1'b0;
      end else begin
         afterFill <= 1'b0;
         case (state)
            idle: begin
               if (loadRequest && !afterFill && !lookupHit) begin
                  state <= fill;
                  fillForDrain <= 1'b0;
                  fillAddress <= lookupAddress;
               end else if (drainLookup) begin
                  fillAddress <= lookupAddress;
                  fillForDrain <= 1'b1;
                  state <= lookupHit ? writeThrough : fill;
               end
            end
            fill: begin
               if (mem.ready) begin
                  valid[fillAddress.fields.index] <= 1'b1;
                  state <= fillForDrain ? writeThrough : idle;
                  // Next cycle serves the held load from the new line.
                  afterFill <= !fillForDrain && !bypass;
               end
            end
            default: begin
               if (mem.ready) begin
                  state <= idle;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == idle && drainLookup && lookupHit) begin
         lines[sb.drainAddr.fields.index] <= mergedLine;
         pendingLine <= mergedLine;
      end
      if (state == fill && mem.ready) begin
         tags[fillAddress.fields.index] <= fillAddress.fields.tag;
         lines[fillAddress.fields.index] <= fillForDrain ? mergedLine : mem.readLine;
         pendingLine <= mergedLine;
      end
   end

endmodule

`default_nettype wire

// File: hw/lineMemory.sv
`default_nettype none

module lineMemory (
   input  logic clk,
   input  logic rst,
   cacheMemIf.memory mem
);

   memStagePkg::cacheLine lines [memStagePkg::MEM_LINES];
   logic [$clog2(memStagePkg::MEM_LATENCY)-1:0] count;
   logic [$clog2(memStagePkg::MEM_LINES)-1:0] slot;

   assign slot = mem.lineAddr[$clog2(memStagePkg::MEM_LINES)-1:0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count <= '0;
         mem.ready <= 1'b0;
         mem.readLine <= '0;
         for (int i = 0; i < memStagePkg::MEM_LINES; i++) begin
            lines[i] <= '0;
         end
      end else if (mem.ready) begin
         // Request is dropped after the ready cycle.
         mem.ready <= 1'b0;
      end else if (mem.read || mem.write) begin
         if (count == memStagePkg::MEM_LATENCY - 1) begin
            count <= '0;
            mem.ready <= 1'b1;
            if (mem.write) begin
               lines[slot] <= mem.writeLine;
            end else begin
               mem.readLine <= lines[slot];
            end
         end else begin
            count <= count + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/memCsr.sv
`default_nettype none

module memCsr (
   input  logic clk,
   input  logic rst,
   input  logic psel,
   input  logic penable,
   input  logic pwrite,
   input  logic [memCsrPkg::APB_ADDR_SIZE-1:0] paddr,
   input  logic [memStagePkg::WORD_SIZE-1:0] pwdata,
   output logic [memStagePkg::WORD_SIZE-1:0] prdata,
   output logic pready,
   input  logic hitEvent,
   input  logic missEvent,
   input  logic drainEvent,
   input  logic [$clog2(memStagePkg::SB_DEPTH):0] occupancy,
   output logic bypass
);

   logic [memStagePkg::WORD_SIZE-1:0] counters [3];
   logic [2:0] events;
   logic ctrlWrite, clearCounters;

   assign pready = 1'b1;
   assign ctrlWrite = psel && penable && pwrite && paddr == memCsrPkg::CTRL_OFFSET;
   // Clear acts on the write itself and is never stored.
   assign clearCounters = ctrlWrite && pwdata[memCsrPkg::CTRL_CLEAR];
   assign events = {drainEvent, missEvent, hitEvent};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bypass <= 1'b0;
         for (int i = 0; i < 3; i++) begin
            counters[i] <= '0;
         end
      end else begin
         if (ctrlWrite) begin
            bypass <= pwdata[memCsrPkg::CTRL_BYPASS];
         end
         for (int i = 0; i < 3; i++) begin
            if (clearCounters) begin
               counters[i] <= '0;
            end else if (events[i] && counters[i] != '1) begin
               counters[i] <= counters[i] + 1'b1;
            end
         end
      end
   end

   always_comb begin
      prdata = '0;
      case (paddr)
         memCsrPkg::CTRL_OFFSET: prdata[memCsrPkg::CTRL_BYPASS] = bypass;
         memCsrPkg::HITS_OFFSET: prdata = counters[0];
         memCsrPkg::MISSES_OFFSET: prdata = counters[1];
         memCsrPkg::DRAINS_OFFSET: prdata = counters[2];
         memCsrPkg::STATUS_OFFSET: prdata[$bits(occupancy)-1:0] = occupancy;
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/memoryStage.sv
`default_nettype none

module memoryStage (
   input  logic clk,
   input  logic rst,
   input  logic [memStagePkg::WORD_SIZE-1:0] ALUResultM,
   input  logic [memStagePkg::WORD_SIZE-1:0] WriteDataM,
   input  logic [memStagePkg::WORD_SIZE-1:0] PCPlus4M,
   input  logic [memStagePkg::REG_ADDR_SIZE-1:0] RdM,
   input  logic RegWriteM,
   input  logic MemWriteM,
   input  logic ReadEnableM,
   input  logic ByteAddressM,
   input  logic [1:0] ResultSrcM,
   input  logic psel,
   input  logic penable,
   input  logic pwrite,
   input  logic [memCsrPkg::APB_ADDR_SIZE-1:0] paddr,
   input  logic [memStagePkg::WORD_SIZE-1:0] pwdata,
   output logic [memStagePkg::WORD_SIZE-1:0] ALUResultW,
   output logic [memStagePkg::WORD_SIZE-1:0] ReadDataW,
   output logic [memStagePkg::WORD_SIZE-1:0] PCPlus4W,
   output logic [memStagePkg::REG_ADDR_SIZE-1:0] RdW,
   output logic RegWriteW,
   output logic [1:0] ResultSrcW,
   output logic CacheStall,
   output logic SBStall,
   output logic [memStagePkg::WORD_SIZE-1:0] prdata,
   output logic pready
);

   memStagePkg::byteAddress addressM;
   logic forwardHit, partialMatch, sbFull, cacheLoad, loadBusy, bypass;
   logic hitEvent, missEvent, drainEvent;
   logic [$clog2(memStagePkg::SB_DEPTH):0] occupancy;
   logic [memStagePkg::WORD_SIZE-1:0] forwardData, cacheData, loadWord, ReadDataM;
   logic [7:0] loadByte;

   cacheMemIf memBus ();
   sbCacheIf drainBus ();

   assign addressM.raw = ALUResultM;

   storeBuffer storeBufferInst (
      .clk(clk), .rst(rst),
      .address(addressM), .data(WriteDataM), .storeByte(ByteAddressM),
      .store(MemWriteM), .load(ReadEnableM),
      .forwardHit(forwardHit), .forwardData(forwardData), .partialMatch(partialMatch),
      .full(sbFull), .occupancy(occupancy), .sb(drainBus)
   );

   // Only loads the buffer cannot answer go to the cache.
   assign cacheLoad = ReadEnableM && !forwardHit && !partialMatch;

   dCache dCacheInst (
      .clk(clk), .rst(rst),
      .loadAddress(addressM), .loadRequest(cacheLoad),
      .loadData(cacheData), .loadBusy(loadBusy), .bypass(bypass),
      .hitEvent(hitEvent), .missEvent(missEvent), .drainEvent(drainEvent),
      .sb(drainBus), .mem(memBus)
   );

   lineMemory lineMemoryInst (.clk(clk), .rst(rst), .mem(memBus));

   memCsr memCsrInst (
      .clk(clk), .rst(rst),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
      .prdata(prdata), .pready(pready),
      .hitEvent(hitEvent), .missEvent(missEvent), .drainEvent(drainEvent),
      .occupancy(occupancy), .bypass(bypass)
   );

   assign CacheStall = loadBusy;
   assign SBStall = (sbFull && MemWriteM) || partialMatch;

   // Load data, with zero-extended byte lane.
   assign loadWord = forwardHit ? forwardData : cacheData;
   assign loadByte = loadWord[addressM.fields.byteOffset * 8 +: 8];
   assign ReadDataM = ByteAddressM ? {{(memStagePkg::WORD_SIZE-8){1'b0}}, loadByte} : loadWord;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ALUResultW <= '0;
         ReadDataW <= '0;
         PCPlus4W <= '0;
         RdW <= '0;
         RegWriteW <= 1'b0;
         ResultSrcW <= '0;
      end else begin
         ALUResultW <= ALUResultM;
         ReadDataW <= ReadDataM;
         PCPlus4W <= PCPlus4M;
         RdW <= RdM;
         // Bubble while stalled.
         RegWriteW <= RegWriteM && !(CacheStall || SBStall);
         ResultSrcW <= (CacheStall || SBStall) ? 2'b00 : ResultSrcM;
      end
   end

endmodule

`default_nettype wire

// File: hw/storeBuffer.sv
`default_nettype none

module storeBuffer (
   input  logic clk,
   input  logic rst,
   input  memStagePkg::byteAddress address,
   input  logic [memStagePkg::WORD_SIZE-1:0] data,
   input  logic storeByte,
   input  logic store,
   input  logic load,
   output logic forwardHit,
   output logic [memStagePkg::WORD_SIZE-1:0] forwardData,
   output logic partialMatch,
   output logic full,
   output logic [$clog2(memStagePkg::SB_DEPTH):0] occupancy,
   sbCacheIf.buffer sb
);

   memStagePkg::byteAddress entryAddr [memStagePkg::SB_DEPTH];
   logic [memStagePkg::WORD_SIZE-1:0] entryData [memStagePkg::SB_DEPTH];
   logic [3:0] entryMask [memStagePkg::SB_DEPTH];
   logic [$clog2(memStagePkg::SB_DEPTH)-1:0] head, tail;
   logic [$clog2(memStagePkg::SB_DEPTH):0] count;
   logic push, pop, matchFound;
   logic [3:0] matchMask;

   assign full = count == memStagePkg::SB_DEPTH;
   assign occupancy = count;
   assign push = store && !full;
   assign pop = sb.drainValid && sb.drainReady;

   assign sb.drainValid = count != 0;
   assign sb.drainAddr = entryAddr[head];
   assign sb.drainData = entryData[head];
   assign sb.drainMask = entryMask[head];

   // Oldest to youngest, so the youngest match is kept.
   always_comb begin
      int unsigned slot;
      matchFound = 1'b0;
      matchMask = '0;
      forwardData = '0;
      for (int k = 0; k < memStagePkg::SB_DEPTH; k++) begin
         slot = (head + k) % memStagePkg::SB_DEPTH;
         if (k < count && entryAddr[slot].raw[memStagePkg::WORD_SIZE-1:2] ==
                          address.raw[memStagePkg::WORD_SIZE-1:2]) begin
            matchFound = 1'b1;
            matchMask = entryMask[slot];
            forwardData = entryData[slot];
         end
      end
   end

   assign forwardHit = load && matchFound && matchMask == 4'hF;
   assign partialMatch = load && matchFound && matchMask != 4'hF;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         head <= '0;
         tail <= '0;
         count <= '0;
      end else begin
         if (push) begin
            tail <= tail + 1'b1;
         end
         if (pop) begin
            head <= head + 1'b1;
         end
         case ({push, pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   // Byte stores replicate the byte; the mask picks the lane.
   always_ff @(posedge clk) begin
      if (push) begin
         entryAddr[tail] <= {address.raw[memStagePkg::WORD_SIZE-1:2], 2'b00};
         entryData[tail] <= storeByte ? {4{data[7:0]}} : data;
         entryMask[tail] <= storeByte ? 4'b0001 << address.fields.byteOffset : 4'hF;
      end
   end

endmodule

`default_nettype wire

// File: sources.f
common/memStagePkg.sv
common/memCsrPkg.sv
common/cacheMemIf.sv
common/sbCacheIf.sv
hw/storeBuffer.sv
hw/lineMemory.sv
hw/memCsr.sv
dCache/dCache.sv
hw/memoryStage.sv
verif/memoryStage_assert.sv
verif/memoryStageTb.sv

// File: verif/memoryStageTb.sv
`default_nettype none

module memoryStageTb;

   localparam int CLOCK_PERIOD = 8;
   localparam int RESET_CYCLES = 16;
   localparam int RANDOM_SEED = 18398;
   localparam int MIXED_OPS = 150;
   localparam int COUNT_LOADS = 40;
   localparam int COUNT_STORES = 20;
   localparam int BURST_STORES = 5;
   localparam int BYPASS_OPS = 180;
   localparam int OP_COUNT =
      MIXED_OPS + COUNT_LOADS + COUNT_STORES + 2 * BURST_STORES + BYPASS_OPS;
   localparam int WATCHDOG_TIME =
      OP_COUNT * (4 * memStagePkg::MEM_LATENCY + 4) * CLOCK_PERIOD;

   logic clk, rst;
   logic [memStagePkg::WORD_SIZE-1:0] ALUResultM, WriteDataM, PCPlus4M;
   logic [memStagePkg::REG_ADDR_SIZE-1:0] RdM, RdW;
   logic RegWriteM, MemWriteM, ReadEnableM, ByteAddressM;
   logic [1:0] ResultSrcM, ResultSrcW;
   logic psel, penable, pwrite, pready;
   logic [memCsrPkg::APB_ADDR_SIZE-1:0] paddr;
   logic [memStagePkg::WORD_SIZE-1:0] pwdata, prdata;
   logic [memStagePkg::WORD_SIZE-1:0] ALUResultW, ReadDataW, PCPlus4W;
   logic RegWriteW, CacheStall, SBStall;

   // Byte-wide view of memory as the program sees it; absent bytes read zero.
   logic [7:0] memModel [logic [31:0]];
   int errors, checks, seedDraw, stallCycles;
   logic sawSbStall, lastWasStore;
   logic [31:0] lastStoreAddr;

   memoryStage DUT (.*);

   initial begin
      clk = 1'b0;
      forever #(CLOCK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_TIME);
      $display("Watchdog expired after %0d time units with the run unfinished", WATCHDOG_TIME);
      $display("Regression failed");
      $finish;
   end

   function automatic logic [7:0] modelByte(input logic [31:0] addr);
      if (memModel.exists(addr)) begin
         return memModel[addr];
      end
      return 8'h00;
   endfunction

   function automatic logic [31:0] expectedLoad(input logic [31:0] addr, input logic byteMode);
      logic [31:0] base;
      base = {addr[31:2], 2'b00};
      if (byteMode) begin
         return {24'h0, modelByte(addr)};
      end
      return {modelByte(base + 3), modelByte(base + 2), modelByte(base + 1), modelByte(base)};
   endfunction

   task automatic applyStore(input logic [31:0] addr, input logic [31:0] data,
                             input logic byteMode);
      logic [31:0] base;
      int i;
      base = {addr[31:2], 2'b00};
      if (byteMode) begin
         memModel[addr] = data[7:0];
      end else begin
         for (i = 0; i < 4; i++) begin
            memModel[base + i] = data[i * 8 +: 8];
         end
      end
   endtask

   // Four tags on indexes 5 and 6, so lines keep evicting each other.
   function automatic logic [31:0] randomAddress(input logic byteMode);
      logic [4:0] word;
      logic [1:0] byteOffset;
      word = 5'($urandom_range(31));
      byteOffset = byteMode ? 2'($urandom_range(3)) : 2'b00;
      return {22'h0, word[3:2], 4'd5 + {3'b000, word[4]}, word[1:0], byteOffset};
   endfunction

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] want);
      checks++;
      assert (got === want) else begin
         errors++;
         $display("error %s: got 0x%h, expected 0x%h", name, got, want);
      end
   endtask

   task automatic holdIdle();
      MemWriteM = 1'b0;
      ReadEnableM = 1'b0;
      RegWriteM = 1'b0;
   endtask

   // Drives one M-stage op and holds it until the stage accepts it.
   task automatic issueOp(input logic store, input logic load, input logic byteMode,
                          input logic [31:0] addr, input logic [31:0] data);
      logic regWrite;
      logic [1:0] resultSrc;
      logic [31:0] expected;
      regWrite = load ? 1'b1 : (store ? 1'b0 : 1'($urandom));
      resultSrc = load ? 2'b01 : {1'($urandom), 1'b0};
      ALUResultM = addr;
      WriteDataM = data;
      PCPlus4M = $urandom;
      RdM = 5'($urandom);
      RegWriteM = regWrite;
      MemWriteM = store;
      ReadEnableM = load;
      ByteAddressM = byteMode;
      ResultSrcM = resultSrc;
      stallCycles = 0;
      @(negedge clk);
      while (CacheStall || SBStall) begin
         if (SBStall && store) begin
            sawSbStall = 1'b1;
         end
         stallCycles++;
         @(posedge clk);
         #1;
         checkValue("RegWriteW", RegWriteW, 0);
         checkValue("ResultSrcW", ResultSrcW, 0);
         @(negedge clk);
      end
      expected = expectedLoad(addr, byteMode);
      if (store) begin
         applyStore(addr, data, byteMode);
      end
      @(posedge clk);
      #1;
      checkValue("ALUResultW", ALUResultW, addr);
      checkValue("PCPlus4W", PCPlus4W, PCPlus4M);
      checkValue("RdW", RdW, RdM);
      checkValue("RegWriteW", RegWriteW, regWrite);
      checkValue("ResultSrcW", ResultSrcW, resultSrc);
      if (load) begin
         checkValue("ReadDataW", ReadDataW, expected);
      end
   endtask

   task automatic runRandomOps(input int count);
      int n, kind;
      logic byteMode, store, load;
      logic [31:0] addr;
      for (n = 0; n < count; n++) begin
         kind = $urandom_range(99);
         byteMode = 1'($urandom);
         store = kind < 40;
         load = kind >= 40 && kind < 85;
         addr = randomAddress(byteMode);
         // Some loads read the word stored just before.
         if (load && lastWasStore && kind < 60) begin
            addr = {lastStoreAddr[31:2], byteMode ? addr[1:0] : 2'b00};
         end
         issueOp(store, load, byteMode, addr, $urandom);
         lastWasStore = store;
         if (store) begin
            lastStoreAddr = addr;
         end
      end
   endtask

   // Access phase of an APB transfer, finished by pready.
   task automatic accessPhase(output logic [31:0] data);
      int waited;
      waited = 0;
      penable = 1'b1;
      @(negedge clk);
      while (!pready && waited < 16) begin
         waited++;
         @(negedge clk);
      end
      assert (pready) else begin
         errors++;
         $display("APB transfer to offset 0x%h never saw pready", paddr);
      end
      data = prdata;
      @(posedge clk);
      #1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic writeCsr(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] ignored;
      holdIdle();
      psel = 1'b1;
      pwrite = 1'b1;
      paddr = addr;
      pwdata = data;
      @(posedge clk);
      #1;
      accessPhase(ignored);
   endtask

   task automatic readCsr(input logic [7:0] addr, output logic [31:0] data);
      holdIdle();
      psel = 1'b1;
      pwrite = 1'b0;
      paddr = addr;
      @(posedge clk);
      #1;
      accessPhase(data);
   endtask

   task automatic waitBufferEmpty();
      logic [31:0] status;
      int polls;
      polls = 0;
      readCsr(memCsrPkg::STATUS_OFFSET, status);
      while (status != 0 && polls < 200) begin
         polls++;
         readCsr(memCsrPkg::STATUS_OFFSET, status);
      end
      assert (status == 0) else begin
         errors++;
         $display("Store buffer still held entries after 200 status polls");
      end
   endtask

   initial begin
      logic [31:0] hits, misses, drains, ctrl;
      logic [31:0] burstAddr [BURST_STORES];
      int i, violations;
      seedDraw = $urandom(RANDOM_SEED);
      rst = 1'b1;
      {ALUResultM, WriteDataM, PCPlus4M, RdM, ResultSrcM, ByteAddressM} = '0;
      holdIdle();
      {psel, penable, pwrite, paddr, pwdata} = '0;
      sawSbStall = 1'b0;
      lastWasStore = 1'b0;
      lastStoreAddr = '0;
      stallCycles = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;

      runRandomOps(MIXED_OPS);

      // Lookups against the counters; the buffer is empty while loads run.
      waitBufferEmpty();
      writeCsr(memCsrPkg::CTRL_OFFSET, 32'h1 << memCsrPkg::CTRL_CLEAR);
      for (i = 0; i < COUNT_LOADS; i++) begin
         issueOp(1'b0, 1'b1, 1'b0, randomAddress(1'b0), 32'h0);
         // A hit never stalls, a miss waits for one line fill.
         assert (stallCycles == 0 || stallCycles == memStagePkg::MEM_LATENCY + 1) else begin
            errors++;
            $display("A load held CacheStall for %0d cycles, neither a hit nor one line fill",
                     stallCycles);
         end
      end
      for (i = 0; i < COUNT_STORES; i++) begin
         issueOp(1'b1, 1'b0, 1'b1, randomAddress(1'b1), $urandom);
      end
      waitBufferEmpty();
      readCsr(memCsrPkg::HITS_OFFSET, hits);
      readCsr(memCsrPkg::MISSES_OFFSET, misses);
      readCsr(memCsrPkg::DRAINS_OFFSET, drains);
      checkValue("DRAINS", drains, COUNT_STORES);
      checkValue("HITS+MISSES", hits + misses, COUNT_LOADS + COUNT_STORES);

      // Back-to-back stores overrun the four entries.
      sawSbStall = 1'b0;
      for (i = 0; i < BURST_STORES; i++) begin
         burstAddr[i] = randomAddress(1'b0);
         issueOp(1'b1, 1'b0, 1'b0, burstAddr[i], $urandom);
      end
      for (i = 0; i < BURST_STORES; i++) begin
         issueOp(1'b0, 1'b1, 1'b0, burstAddr[i], 32'h0);
      end
      assert (sawSbStall) else begin
         errors++;
         $display("Five back-to-back stores never raised SBStall");
      end

      waitBufferEmpty();
      writeCsr(memCsrPkg::CTRL_OFFSET,
               (32'h1 << memCsrPkg::CTRL_BYPASS) | (32'h1 << memCsrPkg::CTRL_CLEAR));
      readCsr(memCsrPkg::CTRL_OFFSET, ctrl);
      checkValue("CTRL", ctrl, 32'h1 << memCsrPkg::CTRL_BYPASS);
      lastWasStore = 1'b0;
      runRandomOps(BYPASS_OPS);
      waitBufferEmpty();
      readCsr(memCsrPkg::HITS_OFFSET, hits);
      readCsr(memCsrPkg::MISSES_OFFSET, misses);
      checkValue("HITS", hits, 0);
      assert (misses > 0) else begin
         errors++;
         $display("Miss counter did not move while bypass was set");
      end
      writeCsr(memCsrPkg::CTRL_OFFSET, 32'h0);

      holdIdle();
      repeat (4) @(posedge clk);
      violations = DUT.handshakeChecks.violations;
      $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
               checks, errors, violations);
      if (errors == 0 && violations == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/memoryStage_assert.sv
`default_nettype none

module memoryStageAssert (
   input logic clk,
   input logic rst,
   input logic memRead,
   input logic memWrite,
   input logic memReady,
   input logic drainValid,
   input logic drainReady,
   input logic [memStagePkg::WORD_SIZE-1:0] drainAddr,
   input logic [memStagePkg::WORD_SIZE-1:0] drainData,
   input logic [3:0] drainMask,
   input logic cacheStall,
   input logic sbStall,
   input logic regWriteW
);

   int violations;

   // A request starts when raised, or when it continues past a ready cycle.
   logic memRequest;
   assign memRequest = memRead || memWrite;

   readWriteExclusive: assert property (@(posedge clk) disable iff (rst)
      !(memRead && memWrite))
      else begin
         violations++;
         $error("Memory read and write were high together");
      end

   drainHeld: assert property (@(posedge clk) disable iff (rst)
      drainValid && !drainReady |=>
         drainValid && $stable(drainAddr) && $stable(drainData) && $stable(drainMask))
      else begin
         violations++;
         $error("Drain outputs changed while waiting for drainReady");
      end

   bubbleAfterStall: assert property (@(posedge clk) disable iff (rst)
      cacheStall || sbStall |=> !regWriteW)
      else begin
         violations++;
         $error("RegWriteW was set in the cycle after a stall");
      end

   fixedLatency: assert property (@(posedge clk) disable iff (rst)
      memRequest && (!$past(memRequest) || $past(memReady)) |->
         !memReady [*memStagePkg::MEM_LATENCY] ##1 memReady)
      else begin
         violations++;
         $error("Memory ready did not come after the fixed latency");
      end

endmodule

bind memoryStage memoryStageAssert handshakeChecks (
   .clk(clk),
   .rst(rst),
   .memRead(memBus.read),
   .memWrite(memBus.write),
   .memReady(memBus.ready),
   .drainValid(drainBus.drainValid),
   .drainReady(drainBus.drainReady),
   .drainAddr(drainBus.drainAddr),
   .drainData(drainBus.drainData),
   .drainMask(drainBus.drainMask),
   .cacheStall(CacheStall),
   .sbStall(SBStall),
   .regWriteW(RegWriteW)
);

`default_nettype wire
